// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_lane_driver
FILELIST  = sources.f
BUILD     = obj_dir
PASS_MSG  = All checks passed

SOURCES   = $(shell grep -v '^+' $(FILELIST))
BIN       = $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD)

// File: design/instr_sequencer.sv
`timescale 1ns/1ps

module instr_sequencer
    import lane_driver_pkg::*;
#(
    parameter int VLANE_NUM       = VLANE_NUM_DEF,
    parameter int MAX_VL_PER_LANE = MAX_VL_PER_LANE_DEF
)
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         start_i,
    input  inst_req_t    req_i,
    output logic         ready_o,
    input  logic         load_valid_i,
    input  logic         load_last_i,
    output logic         ready_for_load_o,
    output logic         store_data_valid_o,
    output step_ctrl_t   ctrl_o,
    output vaddr_t [1:0] raddr_base_o,
    output vaddr_t       waddr_base_o
);

    localparam int CNT_W = $clog2(MAX_VL_PER_LANE) + 1;                     // Holds delay plus limit

    seq_state_e       state_q;
    seq_state_e       state_d;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] rd_limit_d;
    logic [CNT_W-1:0] rd_limit_q;
    logic [CNT_W-1:0] wr_end;
    vl_t              vl_q;
    sew_t             sew_q;
    step_t            delay_q;
    logic             accept;
    logic             rd_step;
    logic             wr_step;
    logic             store_valid_q;

    assign accept     = start_i && ready_o;
    assign ready_o    = (state_q == ST_IDLE);
    assign rd_limit_d = CNT_W'((int'(req_i.vl) + VLANE_NUM - 1) / VLANE_NUM);  // Steps per lane
    assign wr_end     = CNT_W'(delay_q) + rd_limit_q;

    ////////////////////////////////////////////////////////////////////////////
    // Step strobes

    assign rd_step = (state_q == ST_NORMAL || state_q == ST_READ) && (cnt_q < rd_limit_q);

    // Writes trail the reads by the instruction delay, loads are paced from outside
    assign wr_step = (state_q == ST_NORMAL && cnt_q >= CNT_W'(delay_q) && cnt_q < wr_end) ||
                     (state_q == ST_LOAD && load_valid_i);

    ////////////////////////////////////////////////////////////////////////////
    // Mode FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    case (req_i.kind)
                        KIND_NORMAL: state_d = ST_NORMAL;
                        KIND_STORE:  state_d = ST_READ;
                        KIND_LOAD:   state_d = ST_LOAD;
                        default:     state_d = ST_IDLE;
                    endcase
                    if (rd_limit_d == '0 && req_i.kind != KIND_LOAD) begin
                        state_d = ST_IDLE;                                  // Empty vector
                    end
                end
            end
            ST_NORMAL: begin
                if (wr_step && cnt_q == wr_end - 1'b1) begin
                    state_d = ST_IDLE;
                end
            end
            ST_READ: begin
                if (rd_step && cnt_q == rd_limit_q - 1'b1) begin
                    state_d = ST_IDLE;
                end
            end
            ST_LOAD: begin
                if (load_last_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q       <= ST_IDLE;
            cnt_q         <= '0;
            store_valid_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            store_valid_q <= (state_q == ST_READ) && rd_step;               // Lines up with the access stage
            if (accept) begin
                cnt_q <= '0;
            end else if (state_q == ST_NORMAL || state_q == ST_READ) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Instruction fields kept for the whole run
    always_ff @(posedge clk_i) begin
        if (accept) begin
            vl_q       <= req_i.vl;
            sew_q      <= req_i.sew;
            delay_q    <= req_i.inst_delay;
            rd_limit_q <= rd_limit_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs

    assign ready_for_load_o   = (state_q == ST_LOAD);
    assign store_data_valid_o = store_valid_q;

    // Counters load these on the accepting edge
    assign raddr_base_o = req_i.raddr_base;
    assign waddr_base_o = req_i.waddr_base;

    assign ctrl_o.rd_step   = rd_step;
    assign ctrl_o.rd_load   = accept;
    assign ctrl_o.wr_step   = wr_step;
    assign ctrl_o.wr_load   = accept;
    assign ctrl_o.load_mode = (state_q == ST_LOAD);
    assign ctrl_o.sew       = sew_q;
    assign ctrl_o.step      = step_t'(cnt_q);
    assign ctrl_o.vl        = vl_q;

endmodule

// File: design/lane_driver_pkg.sv
package lane_driver_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Defaults handed down by the top level
    localparam int MEM_DEPTH_DEF       = 514;
    localparam int VLANE_NUM_DEF       = 8;
    localparam int MAX_VL_PER_LANE_DEF = 256;
    localparam int R_OPERANDS_DEF      = 2;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    typedef logic [$clog2(MEM_DEPTH_DEF)-1:0] vaddr_t;                      // One lane memory
    typedef logic [$clog2(VLANE_NUM_DEF * MAX_VL_PER_LANE_DEF)-1:0] vl_t;
    typedef logic [$clog2(MAX_VL_PER_LANE_DEF)-1:0] step_t;                 // Element step or delay
    typedef logic [1:0] sew_t;                                              // 0 byte, 1 half, 2 word
    typedef logic [3:0] bwen_t;

    typedef enum logic [1:0] {KIND_NORMAL, KIND_STORE, KIND_LOAD} inst_kind_e;

    typedef enum logic [1:0] {ST_IDLE, ST_NORMAL, ST_READ, ST_LOAD} seq_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    typedef struct packed {
        inst_kind_e   kind;
        vl_t          vl;
        sew_t         sew;
        step_t        inst_delay;
        vaddr_t       waddr_base;
        vaddr_t [1:0] raddr_base;
    } inst_req_t;

    // Per-cycle control from the sequencer
    typedef struct packed {
        logic  rd_step;
        logic  rd_load;
        logic  wr_step;
        logic  wr_load;
        logic  load_mode;
        sew_t  sew;
        step_t step;                                                        // Current read step
        vl_t   vl;
    } step_ctrl_t;

endpackage

// File: design/lane_driver_top.sv
`timescale 1ns/1ps

module lane_driver_top
    import lane_driver_pkg::*;
#(
    parameter int MEM_DEPTH       = MEM_DEPTH_DEF,
    parameter int VLANE_NUM       = VLANE_NUM_DEF,
    parameter int MAX_VL_PER_LANE = MAX_VL_PER_LANE_DEF,
    parameter int R_OPERANDS      = R_OPERANDS_DEF
)
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    // Instruction handshake
    input  logic                    start_i,
    input  inst_req_t               req_i,
    output logic                    ready_o,
    // Load unit
    input  logic                    load_valid_i,
    input  logic                    load_last_i,
    input  bwen_t [VLANE_NUM-1:0]   load_bwen_i,
    output logic                    ready_for_load_o,
    output logic                    store_data_valid_o,
    // Register file
    output logic                    vrf_ren_o,
    output logic                    vrf_wen_o,
    output vaddr_t [R_OPERANDS-1:0] vrf_raddr_o,
    output vaddr_t                  vrf_waddr_o,
    output bwen_t [VLANE_NUM-1:0]   vrf_bwen_o,
    output logic [VLANE_NUM-1:0]    rd_valid_o
);

    step_ctrl_t              ctrl;
    vaddr_t [1:0]            raddr_base;
    vaddr_t                  waddr_base;
    vaddr_t [R_OPERANDS-1:0] raddr;

    instr_sequencer #(
        .VLANE_NUM       (VLANE_NUM),
        .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
    ) u_instr_sequencer (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .start_i            (start_i),
        .req_i              (req_i),
        .ready_o            (ready_o),
        .load_valid_i       (load_valid_i),
        .load_last_i        (load_last_i),
        .ready_for_load_o   (ready_for_load_o),
        .store_data_valid_o (store_data_valid_o),
        .ctrl_o             (ctrl),
        .raddr_base_o       (raddr_base),
        .waddr_base_o       (waddr_base)
    );

    // One read address counter per source operand
    for (genvar i = 0; i < R_OPERANDS; i++) begin : g_raddr
        operand_addr_counter #(
            .MEM_DEPTH (MEM_DEPTH)
        ) u_raddr_cnt (
            .clk_i  (clk_i),
            .rst_i  (rst_i),
            .base_i (raddr_base[i]),
            .load_i (ctrl.rd_load),
            .step_i (ctrl.rd_step),
            .sew_i  (ctrl.sew),
            .addr_o (raddr[i])
        );
    end

    vrf_access_stage #(
        .VLANE_NUM (VLANE_NUM),
        .MEM_DEPTH (MEM_DEPTH)
    ) u_vrf_access_stage (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .ctrl_i       (ctrl),
        .raddr_i      (raddr),
        .waddr_base_i (waddr_base),
        .load_bwen_i  (load_bwen_i),
        .vrf_ren_o    (vrf_ren_o),
        .vrf_wen_o    (vrf_wen_o),
        .vrf_raddr_o  (vrf_raddr_o),
        .vrf_waddr_o  (vrf_waddr_o),
        .vrf_bwen_o   (vrf_bwen_o),
        .rd_valid_o   (rd_valid_o)
    );

endmodule

// File: design/operand_addr_counter.sv
`timescale 1ns/1ps

module operand_addr_counter
    import lane_driver_pkg::*;
#(
    parameter int MEM_DEPTH = MEM_DEPTH_DEF
)
(
    input  logic   clk_i,
    input  logic   rst_i,
    input  vaddr_t base_i,
    input  logic   load_i,
    input  logic   step_i,
    input  sew_t   sew_i,
    output vaddr_t addr_o
);

    localparam vaddr_t ADDR_LAST = vaddr_t'(MEM_DEPTH - 1);

    vaddr_t     addr_q;
    logic [1:0] sub_q;                                                      // Element inside the word
    logic [1:0] sub_last;

    // Elements per word minus one
    always_comb begin
        case (sew_i)
            2'd0:    sub_last = 2'd3;
            2'd1:    sub_last = 2'd1;
            default: sub_last = 2'd0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_q <= '0;
            sub_q  <= '0;
        end else if (load_i) begin
            addr_q <= base_i;
            sub_q  <= '0;
        end else if (step_i) begin
            if (sub_q == sub_last) begin
                sub_q  <= '0;
                addr_q <= (addr_q == ADDR_LAST) ? '0 : addr_q + 1'b1;       // Wrap at memory end
            end else begin
                sub_q <= sub_q + 1'b1;
            end
        end
    end

    assign addr_o = addr_q;

endmodule

// File: design/vrf_access_stage.sv
`timescale 1ns/1ps

module vrf_access_stage
    import lane_driver_pkg::*;
#(
    parameter int VLANE_NUM = VLANE_NUM_DEF,
    parameter int MEM_DEPTH = MEM_DEPTH_DEF
)
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  step_ctrl_t            ctrl_i,
    input  vaddr_t [1:0]          raddr_i,
    input  vaddr_t                waddr_base_i,
    input  bwen_t [VLANE_NUM-1:0] load_bwen_i,
    output logic                  vrf_ren_o,
    output logic                  vrf_wen_o,
    output vaddr_t [1:0]          vrf_raddr_o,
    output vaddr_t                vrf_waddr_o,
    output bwen_t [VLANE_NUM-1:0] vrf_bwen_o,
    output logic [VLANE_NUM-1:0]  rd_valid_o
);

    sew_t                  wr_sew;
    vaddr_t                waddr;
    bwen_t                 onehot_q;
    logic                  half_q;
    bwen_t                 bwen_pat;
    bwen_t [VLANE_NUM-1:0] bwen_d;
    logic [VLANE_NUM-1:0]  lane_valid;

    assign wr_sew = ctrl_i.load_mode ? sew_t'(2) : ctrl_i.sew;              // Loads write whole words

    operand_addr_counter #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_waddr_cnt (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .base_i (waddr_base_i),
        .load_i (ctrl_i.wr_load),
        .step_i (ctrl_i.wr_step),
        .sew_i  (wr_sew),
        .addr_o (waddr)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Byte enables

    // Byte pointer and halfword toggle restart with each instruction
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            onehot_q <= 4'b0001;
            half_q   <= 1'b0;
        end else if (ctrl_i.wr_load) begin
            onehot_q <= 4'b0001;
            half_q   <= 1'b0;
        end else if (ctrl_i.wr_step) begin
            onehot_q <= {onehot_q[2:0], onehot_q[3]};
            half_q   <= ~half_q;
        end
    end

    always_comb begin
        case (ctrl_i.sew)
            2'd0:    bwen_pat = onehot_q;
            2'd1:    bwen_pat = half_q ? 4'b1100 : 4'b0011;
            default: bwen_pat = 4'b1111;
        endcase
        for (int l = 0; l < VLANE_NUM; l++) begin
            bwen_d[l]     = ctrl_i.load_mode ? load_bwen_i[l] : bwen_pat;
            // Element index of this lane against the vector length
            lane_valid[l] = (int'(ctrl_i.step) * VLANE_NUM + l) < int'(ctrl_i.vl);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output registers

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            vrf_ren_o  <= 1'b0;
            vrf_wen_o  <= 1'b0;
            rd_valid_o <= '0;
            vrf_bwen_o <= '0;
        end else begin
            vrf_ren_o  <= ctrl_i.rd_step;
            vrf_wen_o  <= ctrl_i.wr_step;
            rd_valid_o <= ctrl_i.rd_step ? lane_valid : '0;
            vrf_bwen_o <= ctrl_i.wr_step ? bwen_d : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        vrf_raddr_o <= raddr_i;
        vrf_waddr_o <= waddr;
    end

endmodule

// File: sources.f
design/lane_driver_pkg.sv
design/operand_addr_counter.sv
design/instr_sequencer.sv
design/vrf_access_stage.sv
design/lane_driver_top.sv
tb/tb_lane_driver.sv

// File: tb/lane_driver_stimulus.txt
# kind vl sew delay waddr raddr0 raddr1 load_beats exp_rd exp_wr, all hex
# kind 0 normal, 1 store, 2 load; sew 0 byte, 1 half, 2 word
0 20 2 03 100 010 040 0 04 04
0 15 0 00 080 000 020 0 03 03
0 3c 1 05 1f0 0a0 0b0 0 08 08
1 28 2 00 000 050 060 0 05 00
2 40 2 00 120 000 000 6 00 06
0 64 0 0a 000 200 1ff 0 0d 0d
1 09 1 02 000 030 031 0 02 00
2 10 0 00 1fe 000 000 5 00 05
0 08 1 01 00c 004 008 0 01 01
2 08 2 00 010 000 000 1 00 01
0 11 2 14 040 070 071 0 03 03

// File: tb/tb_lane_driver.sv
`timescale 1ns/1ps

module tb_lane_driver
    import lane_driver_pkg::*;
();

    localparam int VLANE   = VLANE_NUM_DEF;
    localparam int DEPTH   = MEM_DEPTH_DEF;
    localparam int TIMEOUT = 1000;                                          // Cycles per wait

    typedef struct packed {
        inst_req_t   req;
        logic [15:0] load_beats;
        logic [15:0] exp_rd;
        logic [15:0] exp_wr;
    } stim_line_t;

    logic                        clk_i;
    logic                        rst_i;
    logic                        start_i;
    inst_req_t                   req_i;
    logic                        ready_o;
    logic                        load_valid_i;
    logic                        load_last_i;
    bwen_t [VLANE-1:0]           load_bwen_i;
    logic                        ready_for_load_o;
    logic                        store_data_valid_o;
    logic                        vrf_ren_o;
    logic                        vrf_wen_o;
    vaddr_t [R_OPERANDS_DEF-1:0] vrf_raddr_o;
    vaddr_t                      vrf_waddr_o;
    bwen_t [VLANE-1:0]           vrf_bwen_o;
    logic [VLANE-1:0]            rd_valid_o;

    stim_line_t         stim_q[$];
    logic [VLANE*4-1:0] bwen_q[$];                                          // Driven load enables
    int                 seed = 32'h50d1c4a0;
    int                 errors;
    int                 tests_run;
    int                 tests_failed;
    logic               hung;

    lane_driver_top #(
        .MEM_DEPTH       (DEPTH),
        .VLANE_NUM       (VLANE),
        .MAX_VL_PER_LANE (MAX_VL_PER_LANE_DEF),
        .R_OPERANDS      (R_OPERANDS_DEF)
    ) u_lane_driver_top (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .start_i            (start_i),
        .req_i              (req_i),
        .ready_o            (ready_o),
        .load_valid_i       (load_valid_i),
        .load_last_i        (load_last_i),
        .load_bwen_i        (load_bwen_i),
        .ready_for_load_o   (ready_for_load_o),
        .store_data_valid_o (store_data_valid_o),
        .vrf_ren_o          (vrf_ren_o),
        .vrf_wen_o          (vrf_wen_o),
        .vrf_raddr_o        (vrf_raddr_o),
        .vrf_waddr_o        (vrf_waddr_o),
        .vrf_bwen_o         (vrf_bwen_o),
        .rd_valid_o         (rd_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    // Base plus step, scaled by elements per word, wrapping at the memory end
    function automatic vaddr_t expect_addr(vaddr_t base, int k, sew_t sew);
        return vaddr_t'((int'(base) + (k >> (2 - int'(sew)))) % DEPTH);
    endfunction

    function automatic logic [VLANE-1:0] expect_mask(int k, int vl);
        logic [VLANE-1:0] m;
        for (int l = 0; l < VLANE; l++) begin
            m[l] = (k * VLANE + l) < vl;
        end
        return m;
    endfunction

    function automatic logic [VLANE*4-1:0] expect_bwen(int k, sew_t sew);
        bwen_t pat;
        case (sew)
            2'd0:    pat = bwen_t'(1 << (k % 4));
            2'd1:    pat = (k % 2 == 1) ? 4'b1100 : 4'b0011;
            default: pat = 4'b1111;
        endcase
        return {VLANE{pat}};                                                // Same in every lane
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic report_wrong_value(string name, logic [31:0] got, logic [31:0] exp);
        $display("MISMATCH %s: got %0h, expected %0h", name, got, exp);
        errors++;
    endtask

    task automatic read_stimulus();
        int         fd;
        int         n;
        int         f[10];
        string      line;
        stim_line_t s;
        fd = $fopen("tb/lane_driver_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the stimulus file could not be opened");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.substr(0, 0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                            f[4], f[5], f[6], f[7], f[8], f[9]);
                if (n == 10) begin
                    s.req.kind          = inst_kind_e'(f[0]);
                    s.req.vl            = vl_t'(f[1]);
                    s.req.sew           = sew_t'(f[2]);
                    s.req.inst_delay    = step_t'(f[3]);
                    s.req.waddr_base    = vaddr_t'(f[4]);
                    s.req.raddr_base[0] = vaddr_t'(f[5]);
                    s.req.raddr_base[1] = vaddr_t'(f[6]);
                    s.load_beats        = 16'(f[7]);
                    s.exp_rd            = 16'(f[8]);
                    s.exp_wr            = 16'(f[9]);
                    stim_q.push_back(s);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!ready_o && n < TIMEOUT);
        if (!ready_o) begin
            $display("ERROR: ready_o never came high");
            errors++;
            hung = 1'b1;
        end
    endtask

    // Drives one load beat or an idle cycle per rising edge
    task automatic drive_load(inout int beats_left);
        logic [VLANE*4-1:0] bw;
        if (beats_left > 0 && ($random(seed) & 3) != 0) begin
            bw = $random(seed);
            load_valid_i <= 1'b1;
            load_bwen_i  <= bw;
            load_last_i  <= (beats_left == 1);
            bwen_q.push_back(bw);
            beats_left--;
        end else begin
            load_valid_i <= 1'b0;
            load_last_i  <= 1'b0;
        end
    endtask

    task automatic run_instr(int i);
        stim_line_t         s;
        int                 rd_cnt;
        int                 wr_cnt;
        int                 n;
        int                 first_rd;
        int                 beats_left;
        int                 err_before;
        logic               is_load;
        logic               is_store;
        logic               exp_ren;
        logic               last_seen;
        vaddr_t             exp_a;
        sew_t               wsew;
        logic [VLANE*4-1:0] exp_bw;
        s          = stim_q[i];
        is_load    = (s.req.kind == KIND_LOAD);
        is_store   = (s.req.kind == KIND_STORE);
        beats_left = is_load ? int'(s.load_beats) : 0;
        err_before = errors;
        rd_cnt     = 0;
        wr_cnt     = 0;
        n          = 0;
        first_rd   = 0;
        last_seen  = 1'b0;
        @(posedge clk_i);                                                   // Accepting edge
        if (i + 1 < stim_q.size()) begin
            req_i <= stim_q[i + 1].req;                                     // Next one waits on ready_o
        end else begin
            start_i <= 1'b0;
        end
        drive_load(beats_left);
        do begin
            @(negedge clk_i);
            n++;
            // Read beats show up on consecutive cycles, one after each step
            exp_ren = !is_load && n >= 2 && n < 2 + int'(s.exp_rd);
            if (n == 1 && ready_o) begin
                $display("ERROR: ready_o stayed high after instruction %0d was taken", i);
                errors++;
            end
            if (vrf_ren_o !== exp_ren) begin
                report_wrong_value("vrf_ren_o", 32'(vrf_ren_o), 32'(exp_ren));
            end
            if (store_data_valid_o !== (is_store && exp_ren)) begin
                report_wrong_value("store_data_valid_o", 32'(store_data_valid_o),
                                   32'(is_store && exp_ren));
            end
            if (ready_for_load_o !== (is_load && !last_seen)) begin
                report_wrong_value("ready_for_load_o", 32'(ready_for_load_o),
                                   32'(is_load && !last_seen));
            end
            if (vrf_ren_o) begin
                if (rd_cnt == 0) begin
                    first_rd = n;
                end
                for (int p = 0; p < 2; p++) begin
                    exp_a = expect_addr(s.req.raddr_base[p], rd_cnt, s.req.sew);
                    if (vrf_raddr_o[p] !== exp_a) begin
                        report_wrong_value($sformatf("vrf_raddr_o[%0d]", p),
                                           32'(vrf_raddr_o[p]), 32'(exp_a));
                    end
                end
                if (rd_valid_o !== expect_mask(rd_cnt, int'(s.req.vl))) begin
                    report_wrong_value("rd_valid_o", 32'(rd_valid_o),
                                       32'(expect_mask(rd_cnt, int'(s.req.vl))));
                end
                rd_cnt++;
            end else if (rd_valid_o !== '0) begin
                report_wrong_value("rd_valid_o", 32'(rd_valid_o), 32'h0);
            end
            if (vrf_wen_o) begin
                wsew  = is_load ? sew_t'(2) : s.req.sew;                    // Loads are word wide
                exp_a = expect_addr(s.req.waddr_base, wr_cnt, wsew);
                if (vrf_waddr_o !== exp_a) begin
                    report_wrong_value("vrf_waddr_o", 32'(vrf_waddr_o), 32'(exp_a));
                end
                if (is_load && bwen_q.size() == 0) begin
                    $display("ERROR: write beat %0d has no matching load beat", wr_cnt);
                    errors++;
                end else begin
                    exp_bw = is_load ? bwen_q.pop_front() : expect_bwen(wr_cnt, s.req.sew);
                    if (vrf_bwen_o !== exp_bw) begin
                        report_wrong_value("vrf_bwen_o", 32'(vrf_bwen_o), 32'(exp_bw));
                    end
                end
                if (!is_load && wr_cnt == 0 && n - first_rd != int'(s.req.inst_delay)) begin
                    report_wrong_value("write start offset", 32'(n - first_rd),
                                       32'(s.req.inst_delay));
                end
                wr_cnt++;
            end
            if (!ready_o) begin
                @(posedge clk_i);
                last_seen = last_seen || (is_load && load_last_i);          // Taken on this edge
                drive_load(beats_left);
            end
        end while (!ready_o && n < TIMEOUT);
        if (!ready_o) begin
            $display("ERROR: instruction %0d did not finish within %0d cycles", i, TIMEOUT);
            errors++;
            hung = 1'b1;
        end
        if (rd_cnt != int'(s.exp_rd)) begin
            report_wrong_value("read beats", 32'(rd_cnt), 32'(s.exp_rd));
        end
        if (wr_cnt != int'(s.exp_wr)) begin
            report_wrong_value("write beats", 32'(wr_cnt), 32'(s.exp_wr));
        end
        if (bwen_q.size() != 0) begin
            $display("ERROR: %0d load beats produced no write beat", bwen_q.size());
            errors++;
            bwen_q.delete();
        end
        tests_run++;
        if (errors == err_before) begin
            $display("Test %0d (%s) passed", i, s.req.kind.name());
        end else begin
            $display("Test %0d (%s) failed", i, s.req.kind.name());
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        int err_before;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        hung         = 1'b0;
        rst_i        = 1'b0;
        start_i      = 1'b0;
        req_i        = '0;
        load_valid_i = 1'b0;
        load_last_i  = 1'b0;
        load_bwen_i  = '0;
        read_stimulus();
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b1;
        @(negedge clk_i);

        err_before = errors;
        if (ready_o !== 1'b1) begin
            report_wrong_value("ready_o", 32'(ready_o), 32'h1);
        end
        if ({vrf_ren_o, vrf_wen_o, store_data_valid_o, ready_for_load_o} !== 4'b0000) begin
            report_wrong_value("strobes", 32'({vrf_ren_o, vrf_wen_o, store_data_valid_o,
                               ready_for_load_o}), 32'h0);
        end
        if (rd_valid_o !== '0) begin
            report_wrong_value("rd_valid_o", 32'(rd_valid_o), 32'h0);
        end
        if (vrf_bwen_o !== '0) begin
            report_wrong_value("vrf_bwen_o", 32'(vrf_bwen_o), 32'h0);
        end
        tests_run++;
        if (errors == err_before) begin
            $display("Test reset passed");
        end else begin
            $display("Test reset failed");
            tests_failed++;
        end

        if (stim_q.size() == 0) begin
            $display("ERROR: no instructions were read from the stimulus file");
            errors++;
        end else begin
            @(posedge clk_i);
            start_i <= 1'b1;
            req_i   <= stim_q[0].req;
            wait_ready();
            for (int i = 0; i < stim_q.size() && !hung; i++) begin
                run_instr(i);                                               // Back to back
            end
        end

        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
